// File: Makefile
VERILATOR ?= verilator
TOP       ?= execTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TEST RESULT: PASS
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
src/execPkg.sv
src/operandLatch.sv
src/decimalAdjust.sv
src/aluUnit.sv
src/registerFile.sv
src/statusReg.sv
src/execTop.sv
verif/execTb.sv

// File: src/aluUnit.sv
// **************************************************
// ALU and adder hold register
// **************************************************
`timescale 1ns/1ps

module aluUnit (
  input  logic             fastClk,
  input  logic             reset,
  input  logic             execValid,
  input  execPkg::opWord_t curOp,
  input  execPkg::byte_t   aluA,
  input  execPkg::byte_t   aluB,
  input  execPkg::byte_t   status,
  output execPkg::aluHold_t holdOut,
  output logic             holdValid
);
  import execPkg::*;

  logic [DataWidth:0] sum;
  logic [4:0]         lowSum;
  logic               carryIn;
  logic               halfCarry;
  logic               binOverflow;
  logic               isArith;
  logic               decimalMode;
  byte_t              decResult;
  logic               decCarry;
  aluHold_t           holdNext;

  assign carryIn = status[StatC];

  // binary adder, B already inverted for subtract
  assign sum = {1'b0, aluA} + {1'b0, aluB} + {{DataWidth{1'b0}}, carryIn};
  // low digit carry for the BCD fix
  assign lowSum = {1'b0, aluA[3:0]} + {1'b0, aluB[3:0]} + {4'b0000, carryIn};
  assign halfCarry = lowSum[4];
  // same input signs, different result sign
  assign binOverflow = (aluA[DataWidth-1] == aluB[DataWidth-1]) &&
                       (sum[DataWidth-1] != aluA[DataWidth-1]);

  assign isArith     = curOp.aluOp inside {opAdc, opSbc};
  assign decimalMode = isArith && status[StatD];

  decimalAdjust decAdj (
    .binResult (sum[DataWidth-1:0]),
    .subtract  (curOp.aluOp == opSbc),
    .halfCarry (halfCarry),
    .binCarry  (sum[DataWidth]),
    .adjResult (decResult),
    .decCarry  (decCarry)
  );

  always_comb begin
    holdNext                = '0;
    holdNext.dstSel         = curOp.dstSel;
    holdNext.flagCmd        = curOp.flagCmd;
    // V stays binary even in decimal mode
    holdNext.overflow       = binOverflow;
    holdNext.updateOverflow = isArith;
    holdNext.updateCarry    = isArith || (curOp.aluOp == opLsr);
    case (curOp.aluOp)
      opAdc, opSbc: begin
        holdNext.result = decimalMode ? decResult : sum[DataWidth-1:0];
        holdNext.carry  = decimalMode ? decCarry : sum[DataWidth];
      end
      opAnd:   holdNext.result = aluA & aluB;
      opEor:   holdNext.result = aluA ^ aluB;
      opOra:   holdNext.result = aluA | aluB;
      opLsr: begin
        // bit 0 drops into carry
        holdNext.result = {1'b0, aluA[DataWidth-1:1]};
        holdNext.carry  = aluA[0];
      end
      opLoad:  holdNext.result = aluB;
      default: holdNext.result = aluA;
    endcase
  end

  // hold register
  always_ff @(posedge fastClk) begin
    if (execValid) begin
      holdOut <= holdNext;
    end
  end

  always_ff @(posedge fastClk) begin
    if (reset) begin
      holdValid <= 1'b0;
    end else begin
      holdValid <= execValid;
    end
  end

endmodule

// File: src/decimalAdjust.sv
// **************************************************
// BCD result correction
// **************************************************
`timescale 1ns/1ps

module decimalAdjust (
  input  execPkg::byte_t binResult,
  input  logic           subtract,
  input  logic           halfCarry,
  input  logic           binCarry,
  output execPkg::byte_t adjResult,
  output logic           decCarry
);
  import execPkg::*;

  logic  lowFix;
  logic  highFix;
  byte_t correction;

  always_comb begin
    // add: fix digit on carry out or value above 9
    // sub: fix digit when it borrowed
    if (subtract) begin
      lowFix  = !halfCarry;
      highFix = !binCarry;
    end else begin
      lowFix  = halfCarry || (binResult[3:0] > 4'd9);
      highFix = binCarry || (binResult > 8'h99);
    end

    // 6 per digit that needs fixing
    correction = {(highFix ? 4'h6 : 4'h0), (lowFix ? 4'h6 : 4'h0)};

    if (subtract) begin
      adjResult = binResult - correction;
      decCarry  = binCarry;
    end else begin
      adjResult = binResult + correction;
      decCarry  = highFix;
    end
  end

endmodule

// File: src/execPkg.sv
// **************************************************
// Execution datapath types
// **************************************************

package execPkg;

  // data path width, fixed at one byte
  localparam int DataWidth = 8;

  typedef logic [DataWidth-1:0] byte_t;

  // alu function select
  // opLoad passes the operand, opTransfer the source register
  typedef enum logic [3:0] {
    opAdc,
    opSbc,
    opAnd,
    opEor,
    opOra,
    opLsr,
    opLoad,
    opTransfer,
    opNone
  } aluOp_e;

  // special bus source or write-back target
  typedef enum logic [1:0] {
    selAccum,
    selX,
    selY,
    selNone
  } regSel_e;

  // explicit set/clear flag commands
  typedef enum logic [2:0] {
    cmdNone,
    cmdSec,
    cmdClc,
    cmdSed,
    cmdCld,
    cmdSei,
    cmdCli,
    cmdClv
  } flagCmd_e;

  // decoded operation as issued
  typedef struct packed {
    aluOp_e   aluOp;
    regSel_e  srcSel;
    regSel_e  dstSel;
    byte_t    operand;
    flagCmd_e flagCmd;
  } opWord_t;

  // adder hold register contents
  typedef struct packed {
    byte_t    result;
    logic     carry;
    logic     overflow;
    logic     updateCarry;
    logic     updateOverflow;
    regSel_e  dstSel;
    flagCmd_e flagCmd;
  } aluHold_t;

  // status bit positions
  localparam int StatC   = 0;
  localparam int StatZ   = 1;
  localparam int StatI   = 2;
  localparam int StatD   = 3;
  localparam int StatB   = 4;
  localparam int StatOne = 5;
  localparam int StatV   = 6;
  localparam int StatN   = 7;

  // I set, bit 5 tied high
  localparam byte_t ResetStatus = 8'h24;

endpackage

// File: src/execTop.sv
// **************************************************
// Execution datapath top
// **************************************************
`timescale 1ns/1ps

module execTop (
  input  logic             fastClk,
  input  logic             reset,
  input  logic             opStrobe,
  input  execPkg::opWord_t opIn,
  output logic             doneStrobe,
  output execPkg::byte_t   accum,
  output execPkg::byte_t   xReg,
  output execPkg::byte_t   yReg,
  output execPkg::byte_t   status
);
  import execPkg::*;

  // stage 1
  opWord_t  curOp;
  byte_t    aluA;
  byte_t    aluB;
  logic     execValid;
  // stage 2
  aluHold_t holdOut;
  logic     holdValid;

  operandLatch opLatch (
    .fastClk, .reset, .opStrobe, .opIn,
    .accum, .xReg, .yReg,
    .curOp, .aluA, .aluB, .execValid
  );

  aluUnit alu (
    .fastClk, .reset, .execValid, .curOp,
    .aluA, .aluB, .status,
    .holdOut, .holdValid
  );

  registerFile regs (
    .fastClk, .reset, .holdValid, .holdOut,
    .accum, .xReg, .yReg, .doneStrobe
  );

  statusReg statReg (
    .fastClk, .reset, .holdValid, .holdOut, .status
  );

endmodule

// File: src/operandLatch.sv
// **************************************************
// Operand capture stage
// **************************************************
`timescale 1ns/1ps

module operandLatch (
  input  logic             fastClk,
  input  logic             reset,
  input  logic             opStrobe,
  input  execPkg::opWord_t opIn,
  input  execPkg::byte_t   accum,
  input  execPkg::byte_t   xReg,
  input  execPkg::byte_t   yReg,
  output execPkg::opWord_t curOp,
  output execPkg::byte_t   aluA,
  output execPkg::byte_t   aluB,
  output logic             execValid
);
  import execPkg::*;

  byte_t specialBus;

  // special bus driver, zero when nothing drives it
  always_comb begin
    case (opIn.srcSel)
      selAccum: specialBus = accum;
      selX:     specialBus = xReg;
      selY:     specialBus = yReg;
      default:  specialBus = '0;
    endcase
  end

  // stage valid, one cycle behind the strobe
  always_ff @(posedge fastClk) begin
    if (reset) begin
      execValid <= 1'b0;
    end else begin
      execValid <= opStrobe;
    end
  end

  // A from special bus, B from operand
  // subtract takes the inverted operand, carry supplies the +1
  always_ff @(posedge fastClk) begin
    if (opStrobe) begin
      curOp <= opIn;
      aluA  <= specialBus;
      aluB  <= (opIn.aluOp == opSbc) ? ~opIn.operand : opIn.operand;
    end
  end

  // previous op must write back before the next reads registers
  strobeSpacing: assert property (@(posedge fastClk) disable iff (reset)
    opStrobe |-> !$past(opStrobe) && !$past(opStrobe, 2));

endmodule

// File: src/registerFile.sv
// **************************************************
// Accumulator and index registers
// **************************************************
`timescale 1ns/1ps

module registerFile (
  input  logic              fastClk,
  input  logic              reset,
  input  logic              holdValid,
  input  execPkg::aluHold_t holdOut,
  output execPkg::byte_t    accum,
  output execPkg::byte_t    xReg,
  output execPkg::byte_t    yReg,
  output logic              doneStrobe
);
  import execPkg::*;

  always_ff @(posedge fastClk) begin
    if (reset) begin
      accum      <= '0;
      xReg       <= '0;
      yReg       <= '0;
      doneStrobe <= 1'b0;
    end else begin
      // done lands with the write-back
      doneStrobe <= holdValid;
      if (holdValid) begin
        // write-back from hold register
        case (holdOut.dstSel)
          selAccum: accum <= holdOut.result;
          selX:     xReg  <= holdOut.result;
          selY:     yReg  <= holdOut.result;
          // flag-only op
          default: begin
          end
        endcase
      end
    end
  end

  // strobe spacing keeps done a single pulse
  donePulse: assert property (@(posedge fastClk) disable iff (reset)
    doneStrobe |=> !doneStrobe);

endmodule

// File: src/statusReg.sv
// **************************************************
// Processor status register
// **************************************************
`timescale 1ns/1ps

module statusReg (
  input  logic              fastClk,
  input  logic              reset,
  input  logic              holdValid,
  input  execPkg::aluHold_t holdOut,
  output execPkg::byte_t    status
);
  import execPkg::*;

  byte_t statusNext;

  always_comb begin
    statusNext = status;
    // N and Z only when something is written
    if (holdOut.dstSel != selNone) begin
      statusNext[StatN] = holdOut.result[DataWidth-1];
      statusNext[StatZ] = (holdOut.result == '0);
    end
    if (holdOut.updateCarry) begin
      statusNext[StatC] = holdOut.carry;
    end
    if (holdOut.updateOverflow) begin
      statusNext[StatV] = holdOut.overflow;
    end
    // flag command last, wins over alu flags
    case (holdOut.flagCmd)
      cmdSec:  statusNext[StatC] = 1'b1;
      cmdClc:  statusNext[StatC] = 1'b0;
      cmdSed:  statusNext[StatD] = 1'b1;
      cmdCld:  statusNext[StatD] = 1'b0;
      cmdSei:  statusNext[StatI] = 1'b1;
      cmdCli:  statusNext[StatI] = 1'b0;
      cmdClv:  statusNext[StatV] = 1'b0;
      // no command, flags as the alu left them
      default: begin
      end
    endcase
    // fixed bits
    statusNext[StatB]   = 1'b0;
    statusNext[StatOne] = 1'b1;
  end

  always_ff @(posedge fastClk) begin
    if (reset) begin
      status <= ResetStatus;
    end else if (holdValid) begin
      status <= statusNext;
    end
  end

  // fixed bits hold across every update
  fixedBits: assert property (@(posedge fastClk) disable iff (reset)
    holdValid |=> status[StatOne] && !status[StatB]);

endmodule

// File: verif/execTb.sv
// **************************************************
// Execution datapath testbench
// **************************************************
`timescale 1ns/1ps

module execTb;
  import execPkg::*;

  localparam int    ClkPeriod   = 100;
  localparam int    DriveDelay  = 10;
  localparam int    ResetCycles = 10;
  localparam int    CyclesPerOp = 6;
  localparam int    MaxOps      = 64;
  localparam string TraceFile   = "verif/execTrace.txt";
  // op nibble of the record that ends the trace
  localparam logic [3:0] EndMarker = 4'hf;

  logic     fastClk;
  logic     reset;
  logic     opStrobe;
  opWord_t  opIn;
  logic     doneStrobe;
  byte_t    accum;
  byte_t    xReg;
  byte_t    yReg;
  byte_t    status;

  // one record per op, nibble aligned
  // op, src, dst, operand, flagCmd, then expected accum, x, y, status
  logic [55:0] traceMem [0:MaxOps-1];
  int          numOps;
  logic        traceLoaded;

  execTop dut (
    .fastClk    (fastClk),
    .reset      (reset),
    .opStrobe   (opStrobe),
    .opIn       (opIn),
    .doneStrobe (doneStrobe),
    .accum      (accum),
    .xReg       (xReg),
    .yReg       (yReg),
    .status     (status)
  );

  initial begin
    fastClk = 1'b0;
    forever #(ClkPeriod / 2) fastClk = ~fastClk;
  end

  task automatic stopOnFailure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic failWithReason(input string reason);
    $display("%s", reason);
    stopOnFailure();
  endtask

  task automatic checkValue(input string name, input byte_t actual, input byte_t expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 8'h%02h, expected 8'h%02h", name, actual, expected);
      stopOnFailure();
    end
  endtask

  // read records up to the end marker
  task automatic loadTrace();
    int idx;
    $readmemh(TraceFile, traceMem);
    numOps = -1;
    idx = 0;
    while ((idx < MaxOps) && (numOps < 0)) begin
      if (traceMem[idx][55:52] === EndMarker) begin
        numOps = idx;
      end
      idx++;
    end
    if (numOps <= 0) begin
      failWithReason("trace file has no end marker or holds no operations");
    end
    traceLoaded = 1'b1;
  endtask

  // entered and left just after a rising edge
  task automatic runOp(input int idx);
    logic [55:0] rec;
    opWord_t     op;
    int          waitCycles;
    rec        = traceMem[idx];
    op.aluOp   = aluOp_e'(rec[55:52]);
    op.srcSel  = regSel_e'(rec[49:48]);
    op.dstSel  = regSel_e'(rec[45:44]);
    op.operand = rec[43:36];
    op.flagCmd = flagCmd_e'(rec[34:32]);
    opStrobe   = 1'b1;
    opIn       = op;
    // strobe seen at this edge
    @(posedge fastClk);
    #DriveDelay;
    opStrobe   = 1'b0;
    waitCycles = 0;
    while (doneStrobe !== 1'b1) begin
      if (waitCycles == 2) begin
        failWithReason($sformatf("doneStrobe did not arrive within 2 cycles for trace op %0d",
                                 idx));
      end
      @(posedge fastClk);
      #DriveDelay;
      waitCycles++;
    end
    // done lands exactly two edges after the strobe edge
    checkValue("doneStrobe latency", 8'(waitCycles), 8'd2);
    // two idle cycles keep the strobe spacing
    @(posedge fastClk);
    #DriveDelay;
    // done is a single cycle pulse
    checkValue("doneStrobe", {7'b0000000, doneStrobe}, 8'h00);
    @(posedge fastClk);
    #DriveDelay;
    checkValue("accum", accum, rec[31:24]);
    checkValue("xReg", xReg, rec[23:16]);
    checkValue("yReg", yReg, rec[15:8]);
    checkValue("status", status, rec[7:0]);
  endtask

  // time budget from trace length
  initial begin
    wait (traceLoaded === 1'b1);
    #(ClkPeriod * (ResetCycles + numOps * CyclesPerOp));
    $display("watchdog expired before all trace operations completed");
    stopOnFailure();
  end

  initial begin
    reset       = 1'b1;
    opStrobe    = 1'b0;
    opIn        = '0;
    numOps      = 0;
    traceLoaded = 1'b0;
    loadTrace();
    repeat (ResetCycles) @(posedge fastClk);
    #DriveDelay;
    reset = 1'b0;
    // state straight out of reset
    checkValue("accum", accum, 8'h00);
    checkValue("xReg", xReg, 8'h00);
    checkValue("yReg", yReg, 8'h00);
    checkValue("status", status, 8'h24);
    checkValue("doneStrobe", {7'b0000000, doneStrobe}, 8'h00);
    for (int i = 0; i < numOps; i++) begin
      runOp(i);
    end
    $display("all %0d trace operations matched", numOps);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: verif/execTrace.txt
// columns: op src dst operand flagCmd _ accum x y status, all hex
// op 0 adc 1 sbc 2 and 3 eor 4 ora 5 lsr 6 load 7 transfer 8 none, sel 0 A 1 X 2 Y 3 none
6_3_0_00_0_00_00_00_26
6_3_0_80_0_80_00_00_a4
6_3_1_05_0_80_05_00_24
6_3_2_ff_0_80_05_ff_a4
8_3_3_00_1_80_05_ff_a5
7_1_0_00_0_05_05_ff_25
7_0_2_00_0_05_05_05_25
8_3_3_00_2_05_05_05_24
6_3_0_50_0_50_05_05_24
0_0_0_50_0_a0_05_05_e4
8_3_3_00_1_a0_05_05_e5
6_3_0_00_0_00_05_05_67
1_0_0_01_0_ff_05_05_a4
8_3_3_00_3_ff_05_05_ac
6_3_0_58_0_58_05_05_2c
0_0_0_46_0_04_05_05_6d
1_0_0_05_0_99_05_05_ac
8_3_3_00_4_99_05_05_a4
0_0_0_01_0_9a_05_05_a4
2_0_0_0f_0_0a_05_05_24
3_0_0_ff_0_f5_05_05_a4
4_0_0_0a_0_ff_05_05_a4
5_0_0_00_0_7f_05_05_25
5_2_2_00_0_7f_05_02_25
5_2_2_00_0_7f_05_01_24
8_3_3_00_6_7f_05_01_20
8_3_3_00_5_7f_05_01_24
0_0_0_01_0_80_05_01_e4
8_3_3_00_7_80_05_01_a4
8_3_3_00_0_80_05_01_a4
f_f_f_ff_f_ff_ff_ff_ff
